// File: common/synth_pkg.sv
package synth_pkg;

   localparam int SAMPLE_W     = 16;
   localparam int ENV_W        = 16;
   localparam int PHASE_W      = 24;
   localparam int TABLE_DEPTH  = 32;
   localparam int TABLE_ADDR_W = $clog2(TABLE_DEPTH);  // Top phase bits address the table
   localparam int MAX_NOTES    = 8;

   typedef logic [SAMPLE_W-1:0] sample_t;  // Unsigned, mid scale is zero
   typedef logic [ENV_W-1:0]    env_t;
   typedef logic [PHASE_W-1:0]  phase_t;

   // Envelope shape, change per sample tick
   localparam env_t ENV_MAX       = 16'hffff;
   localparam env_t SUSTAIN_LEVEL = 16'h4000;
   localparam env_t ATTACK_STEP   = 16'h0200;
   localparam env_t DECAY_STEP    = 16'h0100;
   localparam env_t RELEASE_STEP  = 16'h0100;

   typedef enum logic [2:0] {
      env_idle,
      env_attack,
      env_decay,
      env_sustain,
      env_release
   } env_state_t;

   // C major from C4, phase step at about 16.38 kHz
   function automatic phase_t note_inc(input int idx);
      case (idx)
         0:       return 24'd267946;
         1:       return 24'd300749;
         2:       return 24'd337587;
         3:       return 24'd357660;
         4:       return 24'd401463;
         5:       return 24'd450622;
         6:       return 24'd505802;
         7:       return 24'd535881;
         default: return '0;
      endcase
   endfunction

   // Scale by 1/count in 8-bit fraction
   function automatic logic [7:0] voice_recip(input int count);
      case (count)
         1:       return 8'd255;
         2:       return 8'd128;
         3:       return 8'd85;
         4:       return 8'd64;
         default: return 8'd0;  // Silence, or count out of range
      endcase
   endfunction

endpackage

// File: source/key_regs.sv
`timescale 1ns/100ps

module key_regs #(
   parameter int NUM_NOTES = 8
) (
   input  logic                 clk_100mhz,
   input  logic                 sys_rst,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic                 wb_adr,
   input  logic [7:0]           wb_dat_w,
   input  logic [2:0]           voice_count,
   output logic [7:0]           wb_dat_r,
   output logic                 wb_ack,
   output logic [NUM_NOTES-1:0] key_mask
);

   logic wb_access;

   // New cycle seen, not yet acknowledged
   assign wb_access = wb_cyc && wb_stb && !wb_ack;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         wb_ack   <= 1'b0;
         key_mask <= '0;
      end else begin
         wb_ack <= wb_access;  // Single cycle ack, drops even if stb stays up
         if (wb_access && wb_we && !wb_adr) begin
            key_mask <= wb_dat_w[NUM_NOTES-1:0];
         end
      end
   end

   // Read data, valid with ack
   always_ff @(posedge clk_100mhz) begin
      if (wb_access) begin
         wb_dat_r <= wb_adr ? 8'(voice_count) : 8'(key_mask);
      end
   end

   // Master must see ack low before the next transfer
   ack_single_cycle: assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      wb_ack |=> !wb_ack
   );

endmodule

// File: source/sample_timer.sv
`timescale 1ns/100ps

module sample_timer #(
   parameter int TICK_DIV = 6104
) (
   input  logic clk_100mhz,
   input  logic sys_rst,
   output logic sample_tick
);

   localparam int CNT_W = $clog2(TICK_DIV);

   logic [CNT_W-1:0] count;
   logic             wrap;

   assign wrap = (count == CNT_W'(TICK_DIV - 1));

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         count       <= '0;
         sample_tick <= 1'b0;
      end else begin
         sample_tick <= wrap;  // First tick TICK_DIV cycles after reset
         count       <= wrap ? '0 : count + 1'b1;
      end
   end

   tick_single_cycle: assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      sample_tick |=> !sample_tick
   );

endmodule

// File: voice/envelope_fsm.sv
`timescale 1ns/100ps

module envelope_fsm #(
   parameter int NUM_NOTES = 8
) (
   input  logic                 clk_100mhz,
   input  logic                 sys_rst,
   input  logic                 sample_tick,
   input  logic [NUM_NOTES-1:0] key_mask,
   output synth_pkg::env_t      env_level [NUM_NOTES],
   output logic [NUM_NOTES-1:0] note_active
);
   import synth_pkg::*;

   for (genvar n = 0; n < NUM_NOTES; n++) begin : g_note
      env_state_t     state;
      env_t           level;
      logic [ENV_W:0] attack_sum;  // Spare bit catches the overshoot

      assign attack_sum     = {1'b0, level} + ATTACK_STEP;
      assign env_level[n]   = level;
      assign note_active[n] = (state != env_idle);

      always_ff @(posedge clk_100mhz) begin
         if (sys_rst) begin
            state <= env_idle;
            level <= '0;
         end else if (sample_tick) begin
            case (state)
               env_idle: begin
                  if (key_mask[n]) state <= env_attack;
               end
               env_attack: begin
                  if (!key_mask[n]) begin
                     state <= env_release;
                  end else if (attack_sum >= {1'b0, ENV_MAX}) begin
                     level <= ENV_MAX;  // Saturate at peak
                     state <= env_decay;
                  end else begin
                     level <= attack_sum[ENV_W-1:0];
                  end
               end
               env_decay: begin
                  if (!key_mask[n]) begin
                     state <= env_release;
                  end else if (level <= SUSTAIN_LEVEL + DECAY_STEP) begin
                     level <= SUSTAIN_LEVEL;
                     state <= env_sustain;
                  end else begin
                     level <= level - DECAY_STEP;
                  end
               end
               env_sustain: begin
                  if (!key_mask[n]) state <= env_release;
               end
               env_release: begin
                  if (key_mask[n]) begin
                     state <= env_attack;  // Retrigger from current level
                  end else if (level <= RELEASE_STEP) begin
                     level <= '0;
                     state <= env_idle;
                  end else begin
                     level <= level - RELEASE_STEP;
                  end
               end
               default: begin
                  level <= '0;
                  state <= env_idle;
               end
            endcase
         end
      end

      // Idle notes must contribute nothing to the mix
      idle_is_silent: assert property (
         @(posedge clk_100mhz) disable iff (sys_rst)
         (state == env_idle) |-> (level == '0)
      );
   end

endmodule

// File: voice/note_oscillator.sv
`timescale 1ns/100ps

module note_oscillator #(
   parameter int NUM_NOTES = 8
) (
   input  logic                 clk_100mhz,
   input  logic                 sys_rst,
   input  logic                 sample_tick,
   input  logic [NUM_NOTES-1:0] key_mask,
   output synth_pkg::sample_t   note_sample [NUM_NOTES]
);
   import synth_pkg::*;

   sample_t wave_rom [TABLE_DEPTH];  // One sine period, shared by all notes

   initial begin
      $readmemh("common/wave_table.hex", wave_rom);
   end

   for (genvar n = 0; n < NUM_NOTES; n++) begin : g_note
      phase_t  phase;
      phase_t  phase_next;
      sample_t sample_q;

      // Released keys hold their phase
      assign phase_next     = key_mask[n] ? phase + note_inc(n) : phase;
      assign note_sample[n] = sample_q;

      always_ff @(posedge clk_100mhz) begin
         if (sys_rst) begin
            phase <= '0;
         end else if (sample_tick) begin
            phase <= phase_next;
         end
      end

      // Looked up at the new phase, ready one cycle after the tick
      always_ff @(posedge clk_100mhz) begin
         if (sample_tick) begin
            sample_q <= wave_rom[phase_next[PHASE_W-1 -: TABLE_ADDR_W]];
         end
      end
   end

endmodule

// File: source/voice_mixer.sv
`timescale 1ns/100ps

module voice_mixer #(
   parameter int NUM_NOTES  = 8,
   parameter int NUM_VOICES = 4
) (
   input  logic                 clk_100mhz,
   input  logic                 sys_rst,
   input  logic                 sample_tick,
   input  synth_pkg::sample_t   note_sample [NUM_NOTES],
   input  synth_pkg::env_t      env_level [NUM_NOTES],
   input  logic [NUM_NOTES-1:0] note_active,
   output synth_pkg::sample_t   pcm_sample,
   output logic                 pcm_valid,
   output logic [2:0]           voice_count
);
   import synth_pkg::*;

   localparam int SUM_W  = SAMPLE_W + 2;  // Up to four full scale voices
   localparam int NORM_W = SUM_W + 8;

   logic                       tick_q;  // Envelopes and samples settled
   logic                       s1_valid;
   logic                       s2_valid;
   logic [2:0]                 sel_count;
   logic [2:0]                 s1_count;
   logic [2:0]                 s2_count;
   logic [SAMPLE_W+ENV_W-1:0]  product [NUM_VOICES];
   sample_t                    s1_voice [NUM_VOICES];
   logic [SUM_W-1:0]           voice_sum;
   logic [SUM_W-1:0]           s2_sum;
   logic [NORM_W-1:0]          norm;
   logic [SUM_W-1:0]           scaled;

   ////////////////////////////////////////////////////
   // Voice pick, lowest active notes first
   always_comb begin
      int rank;  // Active notes below note n
      rank = 0;
      for (int v = 0; v < NUM_VOICES; v++) begin
         product[v] = '0;
      end
      for (int n = 0; n < NUM_NOTES; n++) begin
         for (int v = 0; v < NUM_VOICES; v++) begin
            if (note_active[n] && (rank == v)) begin
               product[v] = note_sample[n] * env_level[n];
            end
         end
         if (note_active[n]) rank++;
      end
      sel_count = (rank > NUM_VOICES) ? 3'(NUM_VOICES) : 3'(rank);
   end

   always_comb begin
      voice_sum = '0;
      for (int v = 0; v < NUM_VOICES; v++) begin
         voice_sum = voice_sum + SUM_W'(s1_voice[v]);
      end
   end

   assign norm   = s2_sum * voice_recip(s2_count);
   assign scaled = norm[NORM_W-1:8];

   ////////////////////////////////////////////////////
   // Valid chain, pcm_valid rises three edges after the tick edge
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         tick_q      <= 1'b0;
         s1_valid    <= 1'b0;
         s2_valid    <= 1'b0;
         pcm_valid   <= 1'b0;
         pcm_sample  <= '0;
         voice_count <= '0;
      end else begin
         tick_q    <= sample_tick;
         s1_valid  <= tick_q;
         s2_valid  <= s1_valid;
         pcm_valid <= s2_valid;
         if (s2_valid) begin
            // Clip rounding overshoot to full scale
            pcm_sample  <= (|scaled[SUM_W-1:SAMPLE_W]) ? '1 : scaled[SAMPLE_W-1:0];
            voice_count <= s2_count;
         end
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (tick_q) begin
         for (int v = 0; v < NUM_VOICES; v++) begin
            s1_voice[v] <= product[v][ENV_W +: SAMPLE_W];  // Weighted by level >> 16
         end
         s1_count <= sel_count;
      end
      if (s1_valid) begin
         s2_sum   <= voice_sum;
         s2_count <= s1_count;
      end
   end

endmodule

// File: source/pdm_modulator.sv
`timescale 1ns/100ps

module pdm_modulator (
   input  logic               clk_100mhz,
   input  logic               sys_rst,
   input  synth_pkg::sample_t pcm_sample,
   input  logic               pcm_valid,
   output logic               spk_pdm
);
   import synth_pkg::*;

   sample_t           level;  // Last valid sample
   logic [SAMPLE_W:0] acc;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         level <= '0;
         acc   <= '0;
      end else begin
         if (pcm_valid) level <= pcm_sample;
         acc <= {1'b0, acc[SAMPLE_W-1:0]} + {1'b0, level};
      end
   end

   assign spk_pdm = acc[SAMPLE_W];  // Carry density tracks level / 2^16

endmodule

// File: source/synth_top.sv
`timescale 1ns/100ps

module synth_top #(
   parameter int NUM_NOTES  = 8,     // 1 to MAX_NOTES
   parameter int NUM_VOICES = 4,     // 1 to 4
   parameter int TICK_DIV   = 6104   // About 16.38 kHz at 100 MHz
) (
   input  logic               clk_100mhz,
   input  logic               sys_rst,
   input  logic               wb_cyc,
   input  logic               wb_stb,
   input  logic               wb_we,
   input  logic               wb_adr,
   input  logic [7:0]         wb_dat_w,
   output logic [7:0]         wb_dat_r,
   output logic               wb_ack,
   output synth_pkg::sample_t pcm_sample,
   output logic               pcm_valid,
   output logic               spk_pdm
);
   import synth_pkg::*;

   logic [NUM_NOTES-1:0] key_mask;
   logic [NUM_NOTES-1:0] note_active;
   logic                 sample_tick;
   logic [2:0]           voice_count;
   env_t                 env_level [NUM_NOTES];
   sample_t              note_sample [NUM_NOTES];

   ////////////////////////////////////////////////////
   // Control
   key_regs #(.NUM_NOTES(NUM_NOTES)) u_key_regs (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .voice_count (voice_count),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .key_mask    (key_mask)
   );

   sample_timer #(.TICK_DIV(TICK_DIV)) u_sample_timer (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .sample_tick (sample_tick)
   );

   ////////////////////////////////////////////////////
   // Per-note voices
   envelope_fsm #(.NUM_NOTES(NUM_NOTES)) u_envelope_fsm (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .sample_tick (sample_tick),
      .key_mask    (key_mask),
      .env_level   (env_level),
      .note_active (note_active)
   );

   note_oscillator #(.NUM_NOTES(NUM_NOTES)) u_note_oscillator (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .sample_tick (sample_tick),
      .key_mask    (key_mask),
      .note_sample (note_sample)
   );

   ////////////////////////////////////////////////////
   // Mix and output
   voice_mixer #(
      .NUM_NOTES  (NUM_NOTES),
      .NUM_VOICES (NUM_VOICES)
   ) u_voice_mixer (
      .clk_100mhz  (clk_100mhz),
      .sys_rst     (sys_rst),
      .sample_tick (sample_tick),
      .note_sample (note_sample),
      .env_level   (env_level),
      .note_active (note_active),
      .pcm_sample  (pcm_sample),
      .pcm_valid   (pcm_valid),
      .voice_count (voice_count)
   );

   pdm_modulator u_pdm_modulator (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .pcm_sample (pcm_sample),
      .pcm_valid  (pcm_valid),
      .spk_pdm    (spk_pdm)
   );

endmodule

// File: dv/synth_model.svh
`ifndef SYNTH_MODEL_SVH
`define SYNTH_MODEL_SVH

env_state_t ref_state [MAX_NOTES];
env_t       ref_level [MAX_NOTES];
phase_t     ref_phase [MAX_NOTES];
sample_t    ref_table [TABLE_DEPTH];  // Loaded from the same hex image

// Phase step per note in the C major scale from C4
function automatic phase_t ref_increment(input int idx);
   case (idx)
      0:       return 24'd267946;
      1:       return 24'd300749;
      2:       return 24'd337587;
      3:       return 24'd357660;
      4:       return 24'd401463;
      5:       return 24'd450622;
      6:       return 24'd505802;
      7:       return 24'd535881;
      default: return 24'd0;
   endcase
endfunction

// 1/count as an 8-bit fraction
function automatic int unsigned ref_weight(input int count);
   case (count)
      1:       return 255;
      2:       return 128;
      3:       return 85;
      4:       return 64;
      default: return 0;
   endcase
endfunction

function automatic void reset_model();
   for (int n = 0; n < MAX_NOTES; n++) begin
      ref_state[n] = env_idle;
      ref_level[n] = '0;
      ref_phase[n] = '0;
   end
endfunction

// One sample tick of every note
function automatic void advance_model(input logic [7:0] keys);
   for (int n = 0; n < NUM_NOTES; n++) begin
      case (ref_state[n])
         env_idle: begin
            if (keys[n]) ref_state[n] = env_attack;
         end
         env_attack: begin
            if (!keys[n]) begin
               ref_state[n] = env_release;
            end else if (ENV_MAX - ref_level[n] <= ATTACK_STEP) begin
               ref_level[n] = ENV_MAX;
               ref_state[n] = env_decay;
            end else begin
               ref_level[n] = ref_level[n] + ATTACK_STEP;
            end
         end
         env_decay: begin
            if (!keys[n]) begin
               ref_state[n] = env_release;
            end else if (ref_level[n] - SUSTAIN_LEVEL <= DECAY_STEP) begin
               ref_level[n] = SUSTAIN_LEVEL;
               ref_state[n] = env_sustain;
            end else begin
               ref_level[n] = ref_level[n] - DECAY_STEP;
            end
         end
         env_sustain: begin
            if (!keys[n]) ref_state[n] = env_release;
         end
         default: begin  // Release
            if (keys[n]) begin
               ref_state[n] = env_attack;
            end else if (ref_level[n] <= RELEASE_STEP) begin
               ref_level[n] = '0;
               ref_state[n] = env_idle;
            end else begin
               ref_level[n] = ref_level[n] - RELEASE_STEP;
            end
         end
      endcase
      if (keys[n]) ref_phase[n] = ref_phase[n] + ref_increment(n);
   end
endfunction

// Expected PCM value for the current model state
function automatic sample_t expected_sample();
   longint unsigned sum;
   longint unsigned wave;
   longint unsigned scaled;
   int              used;
   sum  = 0;
   used = 0;
   for (int n = 0; n < NUM_NOTES; n++) begin
      if (ref_state[n] != env_idle && used < NUM_VOICES) begin
         wave = ref_table[ref_phase[n][PHASE_W-1 -: TABLE_ADDR_W]];
         sum  = sum + ((wave * ref_level[n]) >> 16);
         used++;
      end
   end
   scaled = (sum * ref_weight(used)) >> 8;
   if (scaled > 65535) scaled = 65535;
   return sample_t'(scaled);
endfunction

function automatic bit model_silent();
   for (int n = 0; n < NUM_NOTES; n++) begin
      if (ref_state[n] != env_idle) return 1'b0;
   end
   return 1'b1;
endfunction

`endif

// File: dv/synth_tb.sv
`timescale 1ns/100ps

module synth_tb;
   import synth_pkg::*;

   localparam int NUM_NOTES   = 8;
   localparam int NUM_VOICES  = 4;
   localparam int TICK_DIV    = 16;
   localparam int BUS_TIMEOUT = 20;
   localparam int PDM_CYCLES  = 65536;

   logic       clk_100mhz;
   logic       sys_rst;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   logic       wb_adr;
   logic [7:0] wb_dat_w;
   logic [7:0] wb_dat_r;
   logic       wb_ack;
   sample_t    pcm_sample;
   logic       pcm_valid;
   logic       spk_pdm;

   int              err_count;
   int              edge_n;
   int              valid_cnt;
   logic [7:0]      applied_mask;  // Key mask as the DUT holds it
   logic [7:0]      pend_mask;
   bit              pend_valid;
   logic [7:0]      tick_keys [$];  // Mask seen by each tick in flight
   bit              pdm_req;
   int              pdm_cycles;
   longint unsigned pdm_ones;
   longint unsigned pdm_total;
   sample_t         lvl_used;
   sample_t         lvl_next;

   `include "synth_model.svh"

   synth_top #(
      .NUM_NOTES  (NUM_NOTES),
      .NUM_VOICES (NUM_VOICES),
      .TICK_DIV   (TICK_DIV)
   ) u_synth_top (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .pcm_sample (pcm_sample),
      .pcm_valid  (pcm_valid),
      .spk_pdm    (spk_pdm)
   );

   always #5 clk_100mhz = ~clk_100mhz;

   task automatic report_error(input string msg);
      err_count++;
      $display("ERR %0t: %s", $time, msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic report_stall(input string msg);
      err_count++;
      $display("Run stopped at %0t because %s", $time, msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_sample(input sample_t got, input sample_t exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   ////////////////////////////////////////////////////
   // Wishbone master called on a falling edge
   task automatic bus_cycle(input logic we, input logic adr, input logic [7:0] data,
                            output logic [7:0] rdata);
      int waited;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      if (we && !adr) begin
         pend_mask  = data;  // Lands in the DUT on the coming edge
         pend_valid = 1'b1;
      end
      waited = 0;
      do begin
         @(negedge clk_100mhz);
         waited++;
      end while (!wb_ack && waited < BUS_TIMEOUT);
      if (!wb_ack) report_stall("the bus slave never acknowledged");
      if (waited != 1) report_error($sformatf("ack after %0d cycles", waited));
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge clk_100mhz);
      if (wb_ack) report_error("ack held for a second cycle");
   endtask

   task automatic bus_write(input logic adr, input logic [7:0] data);
      logic [7:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic bus_read(input logic adr, output logic [7:0] data);
      bus_cycle(1'b0, adr, 8'h00, data);
   endtask

   task automatic wait_samples(input int n);
      int target;
      int cycles;
      target = valid_cnt + n;
      cycles = 0;
      while (valid_cnt < target) begin
         @(negedge clk_100mhz);
         cycles++;
         if (cycles > (n + 2) * TICK_DIV * 2) report_stall("pcm_valid stopped arriving");
      end
   endtask

   task automatic wait_silence(input int bound);
      int ticks;
      ticks = 0;
      while (!model_silent()) begin
         wait_samples(1);
         ticks++;
         if (ticks > bound) report_error("notes still sounding past the release bound");
      end
   endtask

   ////////////////////////////////////////////////////
   // Timer fires every TICK_DIV edges after reset
   always @(posedge clk_100mhz) begin
      if (sys_rst) begin
         edge_n = 0;
      end else begin
         edge_n++;
         if (edge_n > TICK_DIV && (edge_n - 1) % TICK_DIV == 0) begin
            tick_keys.push_back(applied_mask);
         end
         if (pend_valid) begin
            applied_mask = pend_mask;
            pend_valid   = 1'b0;
         end
      end
   end

   // Compare process
   always @(negedge clk_100mhz) begin
      logic [7:0] keys;
      sample_t    exp_sample;
      if (!sys_rst) begin
         if (pdm_req && pdm_cycles < PDM_CYCLES) begin
            pdm_ones  = pdm_ones + spk_pdm;
            pdm_total = pdm_total + lvl_used;
            pdm_cycles++;
         end
         lvl_used = lvl_next;  // Added to the accumulator on the next edge
         if (pcm_valid) begin
            if (tick_keys.size() == 0) report_error("pcm_valid with no tick before it");
            keys = tick_keys.pop_front();
            advance_model(keys);
            exp_sample = expected_sample();
            check_sample(pcm_sample, exp_sample, "pcm_sample");
            lvl_next = exp_sample;  // Latched by the modulator on the next edge
            valid_cnt++;
         end
      end
   end

   ////////////////////////////////////////////////////
   initial begin
      logic [7:0] mask;
      logic [7:0] rd;
      int         key;
      int         tries;
      longint     diff;
      void'($urandom(32'hc505));
      clk_100mhz   = 1'b0;
      sys_rst      = 1'b1;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = 1'b0;
      wb_dat_w     = 8'h00;
      err_count    = 0;
      edge_n       = 0;
      valid_cnt    = 0;
      applied_mask = 8'h00;
      pend_mask    = 8'h00;
      pend_valid   = 1'b0;
      pdm_req      = 1'b0;
      pdm_cycles   = 0;
      pdm_ones     = 0;
      pdm_total    = 0;
      lvl_used     = '0;
      lvl_next     = '0;
      reset_model();
      $readmemh("common/wave_table.hex", ref_table);
      repeat (2) @(negedge clk_100mhz);
      sys_rst = 1'b0;

      // Register access
      mask = 8'($urandom);
      bus_write(1'b0, mask);
      bus_read(1'b0, rd);
      check_byte(rd, mask, "key mask readback");
      bus_write(1'b1, 8'hff);  // Count is read only
      bus_read(1'b0, rd);
      check_byte(rd, mask, "key mask after write to count");
      bus_write(1'b0, 8'h00);

      // Silence
      wait_silence(300);
      wait_samples(8);
      bus_read(1'b1, rd);
      check_byte(rd, 8'd0, "voice count in silence");

      // Single note through attack, decay and sustain
      key = int'($urandom % NUM_NOTES);
      bus_write(1'b0, 8'(1 << key));
      wait_samples(360);
      bus_read(1'b1, rd);
      check_byte(rd, 8'd1, "voice count with one note");

      // PDM density against the held samples
      pdm_req = 1'b1;
      tries   = 0;
      while (pdm_cycles < PDM_CYCLES) begin
         @(negedge clk_100mhz);
         tries++;
         if (tries > PDM_CYCLES + 100) report_stall("the PDM window never closed");
      end
      diff = longint'(pdm_ones) - longint'(pdm_total >> 16);
      if (diff > 1 || diff < -1) begin
         report_error($sformatf("PDM ones %0d expected %0d", pdm_ones, pdm_total >> 16));
      end

      // Voice limit
      tries = 0;
      do begin
         mask = 8'($urandom);
         tries++;
      end while ($countones(mask) <= NUM_VOICES && tries < 100);
      if ($countones(mask) <= NUM_VOICES) mask = 8'hff;
      bus_write(1'b0, mask);
      wait_samples(40);
      bus_read(1'b1, rd);
      check_byte(rd, 8'(NUM_VOICES), "voice count at the limit");

      // Release down to silence
      bus_write(1'b0, 8'h00);
      wait_silence(ENV_MAX / RELEASE_STEP + 2);
      wait_samples(2);
      bus_read(1'b1, rd);
      check_byte(rd, 8'd0, "voice count after release");

      if (err_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: common/wave_table.hex
// One sine period, 32 unsigned 16-bit samples, mid scale 8000
8000
98F9
B0FB
C71C
DA82
EA6D
F641
FD8A
FFFF
FD8A
F641
EA6D
DA82
C71C
B0FB
98F9
8000
6707
4F05
38E4
257E
1593
09BF
0276
0001
0276
09BF
1593
257E
38E4
4F05
6707

// File: synth.f
+incdir+dv
common/synth_pkg.sv
source/key_regs.sv
source/sample_timer.sv
voice/envelope_fsm.sv
voice/note_oscillator.sv
source/voice_mixer.sv
source/pdm_modulator.sv
source/synth_top.sv
dv/synth_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the synthesizer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module synth_tb \
   -f synth.f -o synth_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/synth_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
   exit 1
fi
exit 0
